// File: Bender.yml
package:
  name: soc_fabric

sources:
  - hdl/soc_pkg.sv
  - hdl/bus_decode.sv
  - hdl/soc_ram.sv
  - hdl/soc_gpio.sv
  - hdl/soc_timer.sv
  - hdl/bus_response.sv
  - hdl/soc_fabric_top.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/soc_fabric_sva.sv
      - verif/tb_soc_fabric.sv

// File: hdl/bus_decode.sv
`timescale 1ns/1ns

module bus_decode import soc_pkg::*; (
  input  logic              req_i,
  input  bus_req_t          pkt_i,
  output logic [NR_DEV-1:0] dev_req_o,
  output bus_dev_e          dev_sel_o
);

  logic hit_ram;
  logic hit_gpio;
  logic hit_timer;

  // Window match on masked address
  assign hit_ram   = (pkt_i.addr & RAM_MASK) == RAM_BASE;
  assign hit_gpio  = (pkt_i.addr & GPIO_MASK) == GPIO_BASE;
  assign hit_timer = (pkt_i.addr & TIMER_MASK) == TIMER_BASE;

  // Windows do not overlap, so at most one hit
  always_comb begin
    dev_req_o = '0;
    dev_sel_o = DevNone; // Idle or unmapped
    if (req_i) begin
      if (hit_ram) begin
        dev_req_o[DevRam] = 1'b1;
        dev_sel_o         = DevRam;
      end else if (hit_gpio) begin
        dev_req_o[DevGpio] = 1'b1;
        dev_sel_o          = DevGpio;
      end else if (hit_timer) begin
        dev_req_o[DevTimer] = 1'b1;
        dev_sel_o           = DevTimer;
      end
      // No hit leaves DevNone, response side flags the error
    end
  end

endmodule

// File: hdl/bus_response.sv
`timescale 1ns/1ns

module bus_response import soc_pkg::*; (
  input  logic              clk_sys_i,
  input  logic              rst_sys_ni,
  input  logic              req_i,
  input  bus_dev_e          dev_sel_i,
  input  logic              we_i,
  input  logic [DATA_W-1:0] ram_rdata_i,
  input  logic [DATA_W-1:0] gpio_rdata_i,
  input  logic [DATA_W-1:0] timer_rdata_i,
  output bus_rsp_t          rsp_o
);

  logic     req_q; // Accepted last cycle
  logic     we_q;
  bus_dev_e sel_q;
  logic [DATA_W-1:0] dev_rdata;

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      req_q <= 1'b0;
      we_q  <= 1'b0;
      sel_q <= DevNone;
    end else begin
      req_q <= req_i;
      we_q  <= we_i;
      sel_q <= dev_sel_i;
    end
  end

  // Pick the device that was addressed
  always_comb begin
    case (sel_q)
      DevRam:   dev_rdata = ram_rdata_i;
      DevGpio:  dev_rdata = gpio_rdata_i;
      DevTimer: dev_rdata = timer_rdata_i;
      default:  dev_rdata = '0; // Nobody claimed it
    endcase
  end

  assign rsp_o.rvalid = req_q;
  assign rsp_o.err    = req_q & (sel_q == DevNone);
  // Reads only, writes and errors return zero
  assign rsp_o.rdata  = (req_q && !we_q) ? dev_rdata : '0;

endmodule

// File: hdl/soc_fabric_top.sv
`timescale 1ns/1ns

module soc_fabric_top import soc_pkg::*; (
  input  logic             clk_sys_i,
  input  logic             rst_sys_ni,
  input  logic             host_req_i,
  input  bus_req_t         host_pkt_i,
  input  logic [GPI_W-1:0] gpio_i,
  output logic             host_gnt_o,
  output bus_rsp_t         host_rsp_o,
  output logic [GPO_W-1:0] gpio_o,
  output logic             timer_irq_o
);

  logic [NR_DEV-1:0] dev_req;   // One-hot device request
  bus_dev_e          dev_sel;
  logic [DATA_W-1:0] ram_rdata;
  logic [DATA_W-1:0] gpio_rdata;
  logic [DATA_W-1:0] timer_rdata;

  // Devices never stall
  assign host_gnt_o = host_req_i;

  bus_decode u_decode (
    .req_i     (host_req_i),
    .pkt_i     (host_pkt_i),
    .dev_req_o (dev_req),
    .dev_sel_o (dev_sel)
  );

  soc_ram u_ram (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .req_i      (dev_req[DevRam]),
    .pkt_i      (host_pkt_i),
    .rdata_o    (ram_rdata)
  );

  soc_gpio u_gpio (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .req_i      (dev_req[DevGpio]),
    .pkt_i      (host_pkt_i),
    .gpio_i     (gpio_i),
    .rdata_o    (gpio_rdata),
    .gpio_o     (gpio_o)
  );

  soc_timer u_timer (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .req_i      (dev_req[DevTimer]),
    .pkt_i      (host_pkt_i),
    .rdata_o    (timer_rdata),
    .irq_o      (timer_irq_o)
  );

  // Response collector, granted request seen here
  bus_response u_response (
    .clk_sys_i     (clk_sys_i),
    .rst_sys_ni    (rst_sys_ni),
    .req_i         (host_gnt_o),
    .dev_sel_i     (dev_sel),
    .we_i          (host_pkt_i.we),
    .ram_rdata_i   (ram_rdata),
    .gpio_rdata_i  (gpio_rdata),
    .timer_rdata_i (timer_rdata),
    .rsp_o         (host_rsp_o)
  );

endmodule

// File: hdl/soc_gpio.sv
`timescale 1ns/1ns

module soc_gpio import soc_pkg::*; (
  input  logic              clk_sys_i,
  input  logic              rst_sys_ni,
  input  logic              req_i,
  input  bus_req_t          pkt_i,
  input  logic [GPI_W-1:0]  gpio_i,
  output logic [DATA_W-1:0] rdata_o,
  output logic [GPO_W-1:0]  gpio_o
);

  logic [GPI_W-1:0]      gpi_meta; // First synchroniser stage
  logic [GPI_W-1:0]      gpi_q;    // Readable input register
  logic [GPO_W-1:0]      gpo_q;
  logic [GPIO_OFF_W-1:0] reg_off;
  logic [DATA_W-1:0]     rdata_d;

  assign reg_off = pkt_i.addr[GPIO_OFF_W-1:0];
  assign gpio_o  = gpo_q;

  // Two flops, pin change visible after two edges
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      gpi_meta <= '0;
      gpi_q    <= '0;
    end else begin
      gpi_meta <= gpio_i;
      gpi_q    <= gpi_meta;
    end
  end

  // Output register, byte writable
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      gpo_q <= '0;
    end else if (req_i && pkt_i.we && reg_off == GpioOut) begin
      gpo_q <= GPO_W'(be_merge(DATA_W'(gpo_q), pkt_i.wdata, pkt_i.be));
    end
  end

  always_comb begin
    case (reg_off)
      GpioIn:  rdata_d = DATA_W'(gpi_q);
      GpioOut: rdata_d = DATA_W'(gpo_q);
      default: rdata_d = '0; // Unused offsets read zero
    endcase
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      rdata_o <= '0;
    end else if (req_i) begin
      rdata_o <= rdata_d;
    end
  end

endmodule

// File: hdl/soc_pkg.sv
package soc_pkg;

  // Bus widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned BE_W   = DATA_W / 8; // One enable per byte lane

  // Address map, each window is base plus size with mask from size
  localparam logic [ADDR_W-1:0] RAM_BASE   = 32'h0010_0000;
  localparam logic [ADDR_W-1:0] RAM_SIZE   = 32'h0000_1000; // 4 KiB
  localparam logic [ADDR_W-1:0] RAM_MASK   = ~(RAM_SIZE - 1);

  localparam logic [ADDR_W-1:0] GPIO_BASE  = 32'h8000_0000;
  localparam logic [ADDR_W-1:0] GPIO_SIZE  = 32'h0000_1000; // 4 KiB
  localparam logic [ADDR_W-1:0] GPIO_MASK  = ~(GPIO_SIZE - 1);

  localparam logic [ADDR_W-1:0] TIMER_BASE = 32'h8000_2000;
  localparam logic [ADDR_W-1:0] TIMER_SIZE = 32'h0000_1000; // 4 KiB
  localparam logic [ADDR_W-1:0] TIMER_MASK = ~(TIMER_SIZE - 1);

  // Offset bits seen by each device
  localparam int unsigned RAM_OFF_W   = $clog2(RAM_SIZE);
  localparam int unsigned GPIO_OFF_W  = $clog2(GPIO_SIZE);
  localparam int unsigned TIMER_OFF_W = $clog2(TIMER_SIZE);

  localparam int unsigned RAM_WORDS = RAM_SIZE / BE_W; // 1024 words
  localparam int unsigned RAM_AW    = $clog2(RAM_WORDS);

  localparam int unsigned GPI_W  = 8;
  localparam int unsigned GPO_W  = 16;
  localparam int unsigned NR_DEV = 3; // RAM, GPIO, timer

  // Host request, sampled by decoder and all devices
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              we;
    logic [BE_W-1:0]   be;
    logic [DATA_W-1:0] wdata;
  } bus_req_t;

  // Response back to the host, one cycle after the grant
  typedef struct packed {
    logic              rvalid;
    logic [DATA_W-1:0] rdata;
    logic              err;
  } bus_rsp_t;

  typedef enum logic [1:0] {DevRam, DevGpio, DevTimer, DevNone} bus_dev_e;

  // Timer register offsets
  typedef enum logic [TIMER_OFF_W-1:0] {
    MtimeLo    = TIMER_OFF_W'(4'h0),
    MtimeHi    = TIMER_OFF_W'(4'h4),
    MtimecmpLo = TIMER_OFF_W'(4'h8),
    MtimecmpHi = TIMER_OFF_W'(4'hC)
  } timer_reg_e;

  typedef enum logic [GPIO_OFF_W-1:0] {
    GpioIn  = GPIO_OFF_W'(4'h0),
    GpioOut = GPIO_OFF_W'(4'h4)
  } gpio_reg_e;

  // Byte-lane write merge shared by all writable registers
  function automatic logic [DATA_W-1:0] be_merge(
    input logic [DATA_W-1:0] old_word,
    input logic [DATA_W-1:0] new_word,
    input logic [BE_W-1:0]   be
  );
    logic [DATA_W-1:0] res;
    res = old_word;
    for (int b = 0; b < BE_W; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_word[8*b +: 8]; // Take enabled lane only
      end
    end
    return res;
  endfunction

endpackage

// File: hdl/soc_ram.sv
`timescale 1ns/1ns

module soc_ram import soc_pkg::*; (
  input  logic              clk_sys_i,
  input  logic              rst_sys_ni,
  input  logic              req_i,
  input  bus_req_t          pkt_i,
  output logic [DATA_W-1:0] rdata_o
);

  logic [DATA_W-1:0] mem [RAM_WORDS]; // Word storage
  logic [RAM_AW-1:0] word_idx;

  // Word index from offset bits inside the window
  assign word_idx = pkt_i.addr[RAM_OFF_W-1:2];

  // Byte-enable write, lanes not enabled keep old value
  always_ff @(posedge clk_sys_i) begin
    if (req_i && pkt_i.we) begin
      mem[word_idx] <= be_merge(mem[word_idx], pkt_i.wdata, pkt_i.be);
    end
  end

  // Registered read port
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      rdata_o <= '0;
    end else if (req_i) begin
      rdata_o <= mem[word_idx]; // Old data on a write, masked off later
    end
  end

endmodule

// File: hdl/soc_timer.sv
`timescale 1ns/1ns

module soc_timer import soc_pkg::*; (
  input  logic              clk_sys_i,
  input  logic              rst_sys_ni,
  input  logic              req_i,
  input  bus_req_t          pkt_i,
  output logic [DATA_W-1:0] rdata_o,
  output logic              irq_o
);

  logic [63:0]            mtime_q;
  logic [63:0]            mtime_d;
  logic [63:0]            mtimecmp_q;
  logic [63:0]            mtimecmp_d;
  logic [TIMER_OFF_W-1:0] reg_off;
  logic                   wr_en;
  logic [DATA_W-1:0]      rdata_d;

  assign reg_off = pkt_i.addr[TIMER_OFF_W-1:0];
  assign wr_en   = req_i & pkt_i.we;

  // Next state, a write to a half wins over the increment
  always_comb begin
    mtime_d    = mtime_q + 64'd1; // Free running
    mtimecmp_d = mtimecmp_q;
    if (wr_en) begin
      case (reg_off)
        MtimeLo:    mtime_d[31:0]     = be_merge(mtime_q[31:0], pkt_i.wdata, pkt_i.be);
        MtimeHi:    mtime_d[63:32]    = be_merge(mtime_q[63:32], pkt_i.wdata, pkt_i.be);
        MtimecmpLo: mtimecmp_d[31:0]  = be_merge(mtimecmp_q[31:0], pkt_i.wdata, pkt_i.be);
        MtimecmpHi: mtimecmp_d[63:32] = be_merge(mtimecmp_q[63:32], pkt_i.wdata, pkt_i.be);
        default: ;
      endcase
    end
  end

  // Read mux over the four halves
  always_comb begin
    case (reg_off)
      MtimeLo:    rdata_d = mtime_q[31:0];
      MtimeHi:    rdata_d = mtime_q[63:32];
      MtimecmpLo: rdata_d = mtimecmp_q[31:0];
      MtimecmpHi: rdata_d = mtimecmp_q[63:32];
      default:    rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1; // Compare far away, no interrupt out of reset
      irq_o      <= 1'b0;
    end else begin
      mtime_q    <= mtime_d;
      mtimecmp_q <= mtimecmp_d;
      // Level interrupt, one cycle behind the compare
      irq_o      <= (mtime_q >= mtimecmp_q);
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      rdata_o <= '0;
    end else if (req_i) begin
      rdata_o <= rdata_d; // Value before this cycle's update
    end
  end

endmodule

// File: soc_fabric_top.f
hdl/soc_pkg.sv
hdl/bus_decode.sv
hdl/soc_ram.sv
hdl/soc_gpio.sv
hdl/soc_timer.sv
hdl/bus_response.sv
hdl/soc_fabric_top.sv
verif/tb_clock_gen.sv
verif/soc_fabric_sva.sv
verif/tb_soc_fabric.sv

// File: verif/soc_fabric_sva.sv
`timescale 1ns/1ns

module soc_fabric_sva import soc_pkg::*; (
  input logic             clk_sys_i,
  input logic             rst_sys_ni,
  input logic             host_req_i,
  input logic             host_gnt_i,
  input bus_rsp_t         host_rsp_i,
  input logic [GPO_W-1:0] gpio_out_i,
  input logic             timer_irq_i
);

  int unsigned fail_cnt = 0; // Failed assertion tally

  // No back-pressure anywhere
  a_gnt_eq_req : assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    host_gnt_i == host_req_i)
    else begin fail_cnt++; $error("grant differs from request"); end

  // Response exactly one cycle after a request
  a_rsp_follows : assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    host_req_i |=> host_rsp_i.rvalid)
    else begin fail_cnt++; $error("rvalid missing one cycle after request"); end

  // And never without one
  a_no_spurious : assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    !host_req_i |=> !host_rsp_i.rvalid)
    else begin fail_cnt++; $error("rvalid without a request"); end

  // Outputs quiet when reset lifts
  a_reset_state : assert property (@(posedge clk_sys_i)
    $rose(rst_sys_ni) |-> gpio_out_i == '0 && !timer_irq_i && !host_rsp_i.rvalid)
    else begin fail_cnt++; $error("outputs not at reset value after reset"); end

endmodule

// File: verif/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk_sys_o,
  output logic rst_sys_no
);

  // 4 ns period
  initial begin
    clk_sys_o = 1'b0;
    forever #2 clk_sys_o = ~clk_sys_o;
  end

  // Reset held for 16 cycles, released on a falling edge
  initial begin
    rst_sys_no = 1'b0;
    repeat (16) @(posedge clk_sys_o);
    @(negedge clk_sys_o);
    rst_sys_no = 1'b1;
  end

endmodule

// File: verif/tb_soc_fabric.sv
`timescale 1ns/1ns

module tb_soc_fabric import soc_pkg::*; ();

  logic              clk_sys;
  logic              rst_sys_n;
  logic              host_req;
  bus_req_t          host_pkt;
  logic              host_gnt;
  bus_rsp_t          host_rsp;
  logic [GPI_W-1:0]  gpio_in;
  logic [GPO_W-1:0]  gpio_out;
  logic              timer_irq;

  integer            seed = 87411;
  int unsigned       errors;
  int unsigned       mark;   // Errors when the current test began
  int unsigned       tests_ok;
  int unsigned       tests_bad;
  int unsigned       waited;
  bus_rsp_t          rsp;    // Last response seen by access
  logic [DATA_W-1:0] ram_model [RAM_WORDS];
  int unsigned       idx_list [$];
  logic [DATA_W-1:0] wdata;
  logic [DATA_W-1:0] first_lo;
  logic [GPO_W-1:0]  gpo_exp;
  logic [BE_W-1:0]   be;
  bus_req_t          seq_pkt [$];
  logic [DATA_W-1:0] seq_rdata [$];
  logic              seq_err [$];
  logic [ADDR_W-1:0] unmapped [5] = '{32'h0000_0000, 32'h0010_1000, 32'h8000_1000,
                                      32'h8000_3004, 32'hFFFF_FFFC};

  tb_clock_gen u_clk (.clk_sys_o(clk_sys), .rst_sys_no(rst_sys_n));

  soc_fabric_top DUT (
    .clk_sys_i   (clk_sys),
    .rst_sys_ni  (rst_sys_n),
    .host_req_i  (host_req),
    .host_pkt_i  (host_pkt),
    .gpio_i      (gpio_in),
    .host_gnt_o  (host_gnt),
    .host_rsp_o  (host_rsp),
    .gpio_o      (gpio_out),
    .timer_irq_o (timer_irq)
  );

  bind soc_fabric_top soc_fabric_sva u_sva (
    .clk_sys_i   (clk_sys_i),
    .rst_sys_ni  (rst_sys_ni),
    .host_req_i  (host_req_i),
    .host_gnt_i  (host_gnt_o),
    .host_rsp_i  (host_rsp_o),
    .gpio_out_i  (gpio_o),
    .timer_irq_i (timer_irq_o)
  );

  // Model of a byte-enabled write
  function automatic logic [DATA_W-1:0] merge_lanes(input logic [DATA_W-1:0] cur,
      input logic [DATA_W-1:0] nxt, input logic [BE_W-1:0] lanes);
    logic [DATA_W-1:0] keep;
    keep = {{8{lanes[3]}}, {8{lanes[2]}}, {8{lanes[1]}}, {8{lanes[0]}}};
    return (nxt & keep) | (cur & ~keep);
  endfunction

  task automatic check(input bit ok, input string msg);
    assert (ok) else begin
      $display("[FAIL] %0t ns: %s", $time, msg);
      errors++;
    end
  endtask

  task automatic abort_run(input string what);
    $display("Timeout: %s", what);
    $display("RESULT: FAIL");
    $finish;
  endtask

  task automatic close_test(input string name);
    if (errors == mark) begin
      tests_ok++;
      $display("Test %s passed", name);
    end else begin
      tests_bad++;
      $display("Test %s failed with %0d errors", name, errors - mark);
    end
    mark = errors;
  endtask

  // Single request, then wait for its rvalid
  task automatic access(input logic [ADDR_W-1:0] addr, input logic we,
      input logic [BE_W-1:0] lanes, input logic [DATA_W-1:0] data);
    int unsigned cnt;
    @(negedge clk_sys);
    host_req = 1'b1;
    host_pkt = '{addr: addr, we: we, be: lanes, wdata: data};
    @(negedge clk_sys);
    host_req = 1'b0; // Accepted at the edge just passed
    cnt = 0;
    while (!host_rsp.rvalid && cnt < 8) begin
      @(negedge clk_sys);
      cnt++;
    end
    if (!host_rsp.rvalid) abort_run($sformatf("no rvalid for request to %h", addr));
    else rsp = host_rsp;
  endtask

  task automatic queue_req(input logic [ADDR_W-1:0] addr, input logic we,
      input logic [DATA_W-1:0] data, input logic [DATA_W-1:0] exp, input logic exp_err);
    seq_pkt.push_back('{addr: addr, we: we, be: {BE_W{we}}, wdata: data});
    seq_rdata.push_back(exp);
    seq_err.push_back(exp_err);
  endtask

  initial begin
    host_req  = 1'b0;
    host_pkt  = '0;
    gpio_in   = '0;
    errors    = 0;
    mark      = 0;
    tests_ok  = 0;
    tests_bad = 0;
    waited    = 0;
    while (rst_sys_n !== 1'b1 && waited < 64) begin
      @(negedge clk_sys);
      waited++;
    end
    if (rst_sys_n !== 1'b1) abort_run("reset was never released");

    // Full words first so every byte of the model is known
    for (int i = 0; i < 16; i++) begin
      idx_list.push_back($unsigned($random(seed)) % RAM_WORDS);
      wdata = $random(seed);
      access(RAM_BASE | (idx_list[i] << 2), 1'b1, '1, wdata);
      ram_model[idx_list[i]] = wdata;
      check(rsp.rdata == '0 && !rsp.err, "RAM write response not zero and clean");
    end
    for (int i = 0; i < 16; i++) begin
      wdata = $random(seed);
      be    = $random(seed);
      access(RAM_BASE | (idx_list[i] << 2), 1'b1, be, wdata);
      ram_model[idx_list[i]] = merge_lanes(ram_model[idx_list[i]], wdata, be);
    end
    for (int i = 0; i < 16; i++) begin
      access(RAM_BASE | (idx_list[i] << 2), 1'b0, '0, '0);
      check(rsp.rdata == ram_model[idx_list[i]] && !rsp.err, $sformatf(
        "RAM word %0d read %h, expected %h", idx_list[i], rsp.rdata, ram_model[idx_list[i]]));
    end
    close_test("ram");

    foreach (unmapped[i]) begin
      access(unmapped[i], 1'b0, '0, '0);
      check(rsp.err && rsp.rdata == '0, $sformatf("read of %h not an error", unmapped[i]));
      access(unmapped[i], 1'b1, '1, $random(seed));
      check(rsp.err && rsp.rdata == '0, $sformatf("write to %h not an error", unmapped[i]));
    end
    close_test("unmapped");

    wdata = $random(seed);
    access(GPIO_BASE | ADDR_W'(GpioOut), 1'b1, '1, wdata);
    gpo_exp = wdata[GPO_W-1:0];
    wdata   = $random(seed);
    be      = $random(seed);
    access(GPIO_BASE | ADDR_W'(GpioOut), 1'b1, be, wdata);
    gpo_exp = GPO_W'(merge_lanes(DATA_W'(gpo_exp), wdata, be));
    check(gpio_out == gpo_exp, $sformatf("gpio_o is %h, expected %h", gpio_out, gpo_exp));
    access(GPIO_BASE | ADDR_W'(GpioOut), 1'b0, '0, '0);
    check(rsp.rdata == DATA_W'(gpo_exp) && !rsp.err, "GpioOut read-back mismatch");
    gpio_in = $random(seed);
    repeat (4) @(negedge clk_sys); // Past the two-flop synchroniser
    access(GPIO_BASE | ADDR_W'(GpioIn), 1'b0, '0, '0);
    check(rsp.rdata == DATA_W'(gpio_in), $sformatf("GpioIn read %h, pins %h", rsp.rdata, gpio_in));
    close_test("gpio");

    check(!timer_irq, "timer_irq_o high with compare at its reset value");
    access(TIMER_BASE | ADDR_W'(MtimecmpHi), 1'b1, '1, '0);
    access(TIMER_BASE | ADDR_W'(MtimeLo), 1'b0, '0, '0);
    access(TIMER_BASE | ADDR_W'(MtimecmpLo), 1'b1, '1, rsp.rdata + 32'd40);
    check(!timer_irq, "timer_irq_o high before the counter reached compare");
    waited = 0;
    while (!timer_irq && waited < 200) begin
      @(negedge clk_sys);
      waited++;
    end
    if (!timer_irq) abort_run("timer_irq_o did not rise after the compare write");
    access(TIMER_BASE | ADDR_W'(MtimecmpHi), 1'b1, '1, '1);
    access(TIMER_BASE | ADDR_W'(MtimecmpLo), 1'b1, '1, '1);
    waited = 0;
    while (timer_irq && waited < 8) begin
      @(negedge clk_sys);
      waited++;
    end
    if (timer_irq) abort_run("timer_irq_o stayed high after compare went back to all ones");
    close_test("timer_irq");

    access(TIMER_BASE | ADDR_W'(MtimeLo), 1'b0, '0, '0);
    first_lo = rsp.rdata;
    access(TIMER_BASE | ADDR_W'(MtimeLo), 1'b0, '0, '0);
    check(rsp.rdata > first_lo, $sformatf("MtimeLo %h not above %h", rsp.rdata, first_lo));
    close_test("timer_count");

    // Alternating targets, one request per cycle
    wdata = $random(seed);
    queue_req(RAM_BASE | (idx_list[0] << 2), 1'b0, '0, ram_model[idx_list[0]], 1'b0);
    queue_req(GPIO_BASE | ADDR_W'(GpioOut), 1'b0, '0, DATA_W'(gpo_exp), 1'b0);
    queue_req(TIMER_BASE | ADDR_W'(MtimecmpHi), 1'b0, '0, '1, 1'b0);
    queue_req(32'h4000_0000, 1'b0, '0, '0, 1'b1);
    queue_req(RAM_BASE | (idx_list[1] << 2), 1'b1, wdata, '0, 1'b0);
    queue_req(RAM_BASE | (idx_list[1] << 2), 1'b0, '0, wdata, 1'b0); // Sees the write before
    queue_req(GPIO_BASE | ADDR_W'(GpioIn), 1'b0, '0, DATA_W'(gpio_in), 1'b0);
    for (int i = 0; i <= seq_pkt.size(); i++) begin
      @(negedge clk_sys);
      if (i > 0) begin
        check(host_rsp.rvalid, $sformatf("no rvalid one cycle after request %0d", i - 1));
        check(host_rsp.rdata == seq_rdata[i-1] && host_rsp.err == seq_err[i-1], $sformatf(
          "request %0d got %h err %b", i - 1, host_rsp.rdata, host_rsp.err));
      end
      host_req = (i < seq_pkt.size());
      if (i < seq_pkt.size()) host_pkt = seq_pkt[i];
    end
    close_test("back_to_back");

    $display("Tests passed: %0d, failed: %0d, assertion failures: %0d",
             tests_ok, tests_bad, DUT.u_sva.fail_cnt);
    if (tests_bad == 0 && DUT.u_sva.fail_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
